//--- source/vp_glue_defs.svh
////////////////////////////////////////
// Widths, enable dividers and bank
// thresholds for the console glue logic
////////////////////////////////////////
`ifndef VP_GLUE_DEFS_SVH
`define VP_GLUE_DEFS_SVH

// Address widths
`define VP_CART_ADDR_W 12
`define VP_ROM_ADDR_W 13

// Enable periods in clk_sys cycles
`define VP_CPU_DIV_NTSC 8
`define VP_CPU_DIV_PAL 12
`define VP_VDC_DIV_NTSC 6
`define VP_VDC_DIV_PAL 10

// Image sizes that switch on the bank bits
`define VP_BANK0_SIZE 4096
`define VP_BANK1_SIZE 8192

`endif

//--- source/vp_glue_pkg.sv
////////////////////////////////////////
// Shared types of the console glue
// Vector typedefs, loader FSM states
// NTSC and PAL colour tables
////////////////////////////////////////
`include "vp_glue_defs.svh"

package vp_glue_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [`VP_CART_ADDR_W-1:0] cart_addr_t;   // Console side
	typedef logic [`VP_ROM_ADDR_W-1:0] rom_addr_t;     // Also the Wishbone address
	typedef logic [15:0] cart_size_t;
	typedef logic [3:0] div_cnt_t;
	typedef logic [3:0] color_idx_t;                   // {r,g,b,luma}
	typedef logic [23:0] rgb24_t;
	typedef logic [17:0] rgb18_t;

	typedef enum logic {
		LOAD_IDLE,
		LOAD_ACK
	} load_state_t;

	////////////////////////////////////////
	// Calibrated colour tables
	////////////////////////////////////////

	localparam rgb24_t palette_ntsc [16] = '{
		24'h000000, 24'h676767,   // Black
		24'h1a37be, 24'h5c80f6,
		24'h006d07, 24'h56c469,
		24'h2aaabe, 24'h77e6eb,
		24'h790000, 24'hc75151,   // Red pair
		24'h94309f, 24'hdc84e8,
		24'h77670b, 24'hc6b86a,
		24'hcecece, 24'hffffff    // Grey and white
	};

	// Saturated set for 50 Hz sets
	localparam rgb24_t palette_pal [16] = '{
		24'h000000, 24'h494949,
		24'h0000b6, 24'h4949ff,
		24'h00b601, 24'h49ff49,
		24'h00b6c9, 24'h49ffff,
		24'hb60000, 24'hff4949,
		24'hb600b6, 24'hff49ff,
		24'hb6b600, 24'hffff49,
		24'hb6b6b6, 24'hffffff
	};

endpackage

//--- source/cart_mem_if.sv
////////////////////////////////////////
// Loader to cartridge ROM connection
// Write port doubling as readback
////////////////////////////////////////

interface cart_mem_if;

	vp_glue_pkg::rom_addr_t wr_addr;   // Readback address when wr_en is low
	vp_glue_pkg::byte_t     wr_data;
	logic                   wr_en;
	vp_glue_pkg::byte_t     rd_data;   // Byte at last cycle's wr_addr

	modport loader (
		output wr_addr,
		output wr_data,
		output wr_en,
		input  rd_data
	);

	modport rom (
		input  wr_addr,
		input  wr_data,
		input  wr_en,
		output rd_data
	);

endinterface

//--- source/vp_clock_enables.sv
////////////////////////////////////////
// CPU and VDC pulse enables
// NTSC or PAL periods, restart on a
// change of the TV standard
////////////////////////////////////////
`include "vp_glue_defs.svh"

module vp_clock_enables (
	input  logic clk_sys,
	input  logic reset,
	input  logic pal_i,
	output logic cpu_en_o,
	output logic vdc_en_o
);

	localparam vp_glue_pkg::div_cnt_t CPU_LAST_NTSC = vp_glue_pkg::div_cnt_t'(`VP_CPU_DIV_NTSC - 1);
	localparam vp_glue_pkg::div_cnt_t CPU_LAST_PAL  = vp_glue_pkg::div_cnt_t'(`VP_CPU_DIV_PAL - 1);
	localparam vp_glue_pkg::div_cnt_t VDC_LAST_NTSC = vp_glue_pkg::div_cnt_t'(`VP_VDC_DIV_NTSC - 1);
	localparam vp_glue_pkg::div_cnt_t VDC_LAST_PAL  = vp_glue_pkg::div_cnt_t'(`VP_VDC_DIV_PAL - 1);

	vp_glue_pkg::div_cnt_t cpu_cnt;
	vp_glue_pkg::div_cnt_t vdc_cnt;
	vp_glue_pkg::div_cnt_t cpu_last;
	vp_glue_pkg::div_cnt_t vdc_last;
	logic                  pal_q;
	logic                  std_change;

	// Follows pal_i while reset is held too
	always_ff @(posedge clk_sys) begin
		pal_q <= pal_i;
	end

	assign std_change = pal_i ^ pal_q;
	assign cpu_last   = pal_q ? CPU_LAST_PAL : CPU_LAST_NTSC;
	assign vdc_last   = pal_q ? VDC_LAST_PAL : VDC_LAST_NTSC;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cpu_cnt  <= '0;
			vdc_cnt  <= '0;
			cpu_en_o <= 1'b0;
			vdc_en_o <= 1'b0;
		end else if (std_change) begin
			cpu_cnt  <= '0;   // New period starts here
			vdc_cnt  <= '0;
			cpu_en_o <= 1'b0;
			vdc_en_o <= 1'b0;
		end else begin
			cpu_en_o <= (cpu_cnt >= cpu_last);
			cpu_cnt  <= (cpu_cnt >= cpu_last) ? '0 : cpu_cnt + 4'd1;
			vdc_en_o <= (vdc_cnt >= vdc_last);
			vdc_cnt  <= (vdc_cnt >= vdc_last) ? '0 : vdc_cnt + 4'd1;
		end
	end

endmodule

//--- source/vp_cart_loader.sv
////////////////////////////////////////
// Cartridge image loader
// Wishbone classic slave, one wait
// cycle per access, image size count
////////////////////////////////////////

module vp_cart_loader (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   load_active_i,

	// Wishbone slave
	input  logic                   wb_cyc_i,
	input  logic                   wb_stb_i,
	input  logic                   wb_we_i,
	input  vp_glue_pkg::rom_addr_t wb_adr_i,
	input  vp_glue_pkg::byte_t     wb_dat_i,
	output vp_glue_pkg::byte_t     wb_dat_o,
	output logic                   wb_ack_o,

	output vp_glue_pkg::cart_size_t cart_size_o,
	cart_mem_if.loader             mem
);

	vp_glue_pkg::load_state_t state;
	logic                     wb_req;
	logic                     wr_accept;
	logic                     load_q;
	logic                     load_rise;

	assign wb_req = wb_cyc_i & wb_stb_i;

	// Only one write per bus cycle, in the wait cycle
	assign wr_accept = (state == vp_glue_pkg::LOAD_IDLE) & wb_req & wb_we_i & load_active_i;

	assign mem.wr_addr = wb_adr_i;
	assign mem.wr_data = wb_dat_i;
	assign mem.wr_en   = wr_accept;

	// Readback byte arrives with the ack
	assign wb_dat_o = mem.rd_data;
	assign wb_ack_o = (state == vp_glue_pkg::LOAD_ACK);

	////////////////////////////////////////
	// Handshake FSM
	////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state <= vp_glue_pkg::LOAD_IDLE;
		end else begin
			case (state)
				vp_glue_pkg::LOAD_IDLE: begin
					if (wb_req)
						state <= vp_glue_pkg::LOAD_ACK;
				end
				vp_glue_pkg::LOAD_ACK: state <= vp_glue_pkg::LOAD_IDLE;   // One ack cycle
				default: state <= vp_glue_pkg::LOAD_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// Image size
	////////////////////////////////////////

	assign load_rise = load_active_i & ~load_q;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			load_q      <= 1'b0;
			cart_size_o <= '0;
		end else begin
			load_q <= load_active_i;
			if (load_rise)
				cart_size_o <= wr_accept ? 16'd1 : 16'd0;   // Keep a first-cycle write
			else if (wr_accept)
				cart_size_o <= cart_size_o + 16'd1;
		end
	end

endmodule

//--- source/vp_cart_rom.sv
////////////////////////////////////////
// Cartridge ROM, 8 KiB
// Load and readback port, console port
// with bank bits gated by image size
////////////////////////////////////////
`include "vp_glue_defs.svh"

module vp_cart_rom (
	input  logic                    clk_sys,
	cart_mem_if.rom                 mem,
	input  vp_glue_pkg::cart_size_t cart_size_i,

	// Console side
	input  vp_glue_pkg::cart_addr_t cart_addr_i,
	input  logic                    bank0_i,
	input  logic                    bank1_i,
	input  logic                    psen_n_i,
	output vp_glue_pkg::byte_t      cart_data_o
);

	localparam int ROM_DEPTH = 1 << `VP_ROM_ADDR_W;
	localparam vp_glue_pkg::cart_size_t BANK0_MIN = vp_glue_pkg::cart_size_t'(`VP_BANK0_SIZE);
	localparam vp_glue_pkg::cart_size_t BANK1_MIN = vp_glue_pkg::cart_size_t'(`VP_BANK1_SIZE);

	vp_glue_pkg::byte_t    storage [ROM_DEPTH];
	vp_glue_pkg::rom_addr_t con_addr;
	logic                  bank0_eff;
	logic                  bank1_eff;
	vp_glue_pkg::byte_t    con_data_q;
	logic                  psen_n_q;

	////////////////////////////////////////
	// Load and readback port
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (mem.wr_en)
			storage[mem.wr_addr] <= mem.wr_data;
		mem.rd_data <= storage[mem.wr_addr];
	end

	////////////////////////////////////////
	// Console port
	////////////////////////////////////////

	// Small images ignore the bank bits
	assign bank0_eff = (cart_size_i >= BANK0_MIN) ? bank0_i : 1'b0;
	assign bank1_eff = (cart_size_i >= BANK1_MIN) ? bank1_i : 1'b0;

	// Console bit 10 does not reach the ROM
	assign con_addr = {
		bank1_eff,
		bank0_eff,
		cart_addr_i[`VP_CART_ADDR_W-1],
		cart_addr_i[9:0]
	};

	always_ff @(posedge clk_sys) begin
		con_data_q <= storage[con_addr];
		psen_n_q   <= psen_n_i;
	end

	assign cart_data_o = psen_n_q ? 8'hff : con_data_q;   // Bus floats high

endmodule

//--- source/vp_palette.sv
////////////////////////////////////////
// Colour lookup for the VGA output
// {r,g,b,luma} to 18-bit RGB
////////////////////////////////////////

module vp_palette (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                vdc_en_i,
	input  logic                pal_i,
	input  logic                r_i,
	input  logic                g_i,
	input  logic                b_i,
	input  logic                luma_i,
	output vp_glue_pkg::rgb18_t rgb_o
);

	vp_glue_pkg::color_idx_t color_idx;
	vp_glue_pkg::rgb24_t     entry;

	assign color_idx = {r_i, g_i, b_i, luma_i};

	// Table chosen by the standard
	assign entry = pal_i ? vp_glue_pkg::palette_pal[color_idx]
	                     : vp_glue_pkg::palette_ntsc[color_idx];

	// Upper six bits per channel, once per pixel
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			rgb_o <= '0;
		end else if (vdc_en_i) begin
			rgb_o <= {entry[23:18], entry[15:10], entry[7:2]};
		end
	end

endmodule

//--- source/vp_glue_top.sv
////////////////////////////////////////
// Console glue top level
// Enables, cartridge load and ROM,
// colour palette
////////////////////////////////////////

module vp_glue_top (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    pal_i,
	output logic                    cpu_en_o,
	output logic                    vdc_en_o,

	// Wishbone image load
	input  logic                    load_active_i,
	input  logic                    wb_cyc_i,
	input  logic                    wb_stb_i,
	input  logic                    wb_we_i,
	input  vp_glue_pkg::rom_addr_t  wb_adr_i,
	input  vp_glue_pkg::byte_t      wb_dat_i,
	output vp_glue_pkg::byte_t      wb_dat_o,
	output logic                    wb_ack_o,

	// Console cartridge bus
	input  vp_glue_pkg::cart_addr_t cart_addr_i,
	input  logic                    bank0_i,
	input  logic                    bank1_i,
	input  logic                    psen_n_i,
	output vp_glue_pkg::byte_t      cart_data_o,

	// Console colour
	input  logic                    r_i,
	input  logic                    g_i,
	input  logic                    b_i,
	input  logic                    luma_i,
	output vp_glue_pkg::rgb18_t     rgb_o
);

	vp_glue_pkg::cart_size_t cart_size;

	cart_mem_if mem_bus ();

	vp_clock_enables u_clock_enables (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.pal_i    (pal_i),
		.cpu_en_o (cpu_en_o),
		.vdc_en_o (vdc_en_o)
	);

	vp_cart_loader u_cart_loader (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.load_active_i (load_active_i),
		.wb_cyc_i      (wb_cyc_i),
		.wb_stb_i      (wb_stb_i),
		.wb_we_i       (wb_we_i),
		.wb_adr_i      (wb_adr_i),
		.wb_dat_i      (wb_dat_i),
		.wb_dat_o      (wb_dat_o),
		.wb_ack_o      (wb_ack_o),
		.cart_size_o   (cart_size),
		.mem           (mem_bus)
	);

	vp_cart_rom u_cart_rom (
		.clk_sys     (clk_sys),
		.mem         (mem_bus),
		.cart_size_i (cart_size),
		.cart_addr_i (cart_addr_i),
		.bank0_i     (bank0_i),
		.bank1_i     (bank1_i),
		.psen_n_i    (psen_n_i),
		.cart_data_o (cart_data_o)
	);

	// Pixel rate is the VDC enable
	vp_palette u_palette (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.vdc_en_i (vdc_en_o),
		.pal_i    (pal_i),
		.r_i      (r_i),
		.g_i      (g_i),
		.b_i      (b_i),
		.luma_i   (luma_i),
		.rgb_o    (rgb_o)
	);

endmodule

//--- dv/vp_glue_assertions.sv
////////////////////////////////////////
// Concurrent checks, bound to the top
// Wishbone ack and pulse enables
////////////////////////////////////////

module vp_glue_assertions (
	input logic clk_sys,
	input logic reset,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_ack_o,
	input logic cpu_en_o,
	input logic vdc_en_o
);

	timeunit 1ns;
	timeprecision 1ps;

	// Single cycle ack
	ack_one_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		wb_ack_o |=> !wb_ack_o)
		else $error("wb_ack_o high for two cycles in a row");

	ack_after_stb: assert property (@(posedge clk_sys) disable iff (reset)
		wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
		else $error("wb_ack_o without a request in the cycle before");

	// Fixed one-cycle wait
	ack_on_time: assert property (@(posedge clk_sys) disable iff (reset)
		(wb_cyc_i && wb_stb_i && !wb_ack_o) |=> wb_ack_o)
		else $error("wb_ack_o missing one cycle after the request");

	////////////////////////////////////////
	// Pulse enables
	////////////////////////////////////////

	cpu_pulse_width: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_en_o |=> !cpu_en_o)
		else $error("cpu_en_o pulse longer than one cycle");

	vdc_pulse_width: assert property (@(posedge clk_sys) disable iff (reset)
		vdc_en_o |=> !vdc_en_o)
		else $error("vdc_en_o pulse longer than one cycle");

endmodule

//--- dv/vp_glue_tb.sv
////////////////////////////////////////
// Testbench for the console glue top
// Image load table, compare tasks,
// watchdog and colour table sweep
////////////////////////////////////////
`include "vp_glue_defs.svh"

module vp_glue_tb;

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		vp_glue_pkg::cart_size_t size;
		logic                    pal;
		logic [1:0]              bank;      // First of the four bank combinations
		vp_glue_pkg::cart_addr_t probe_a;
		vp_glue_pkg::cart_addr_t probe_b;
		vp_glue_pkg::color_idx_t color;
	} load_case_t;

	localparam load_case_t CASES [3] = '{
		'{16'd2048, 1'b0, 2'b00, 12'h3c1, 12'hc3e, 4'h9},
		'{16'd4096, 1'b1, 2'b01, 12'h5a5, 12'ha5a, 4'h6},
		'{16'd8192, 1'b0, 2'b10, 12'h7ff, 12'h800, 4'hf}
	};
	localparam int IMAGE_BYTES = CASES[0].size + CASES[1].size + CASES[2].size;
	// Each byte written and read back, three cycles per bus access
	localparam int TIMEOUT_CYCLES = IMAGE_BYTES * 2 * 3 + 2000;

	logic clk_sys, reset, pal_i, cpu_en_o, vdc_en_o;
	logic load_active_i, wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
	logic bank0_i, bank1_i, psen_n_i;
	logic r_i, g_i, b_i, luma_i;
	vp_glue_pkg::rom_addr_t  wb_adr_i;
	vp_glue_pkg::byte_t      wb_dat_i, wb_dat_o, cart_data_o;
	vp_glue_pkg::cart_addr_t cart_addr_i;
	vp_glue_pkg::rgb18_t     rgb_o;

	vp_glue_pkg::byte_t model [1 << `VP_ROM_ADDR_W];   // Expected ROM contents
	integer seed = 32'heaa5_bbd3;
	int     cycle_cnt = 0;

	vp_glue_top UUT (.*);

	bind vp_glue_top vp_glue_assertions u_assertions (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1);
	endtask

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			report_failure("Timeout: the run did not finish within the cycle limit");
	end

	////////////////////////////////////////
	// Compare tasks and expected values
	////////////////////////////////////////

	task automatic check_byte(input string name, input vp_glue_pkg::byte_t got,
		input vp_glue_pkg::byte_t exp);
		if (got !== exp)
			report_failure($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_rgb(input string name, input vp_glue_pkg::rgb18_t got,
		input vp_glue_pkg::rgb18_t exp);
		if (got !== exp)
			report_failure($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_count(input string name, input vp_glue_pkg::cart_size_t got,
		input vp_glue_pkg::cart_size_t exp);
		if (got !== exp)
			report_failure($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
	endtask

	function automatic vp_glue_pkg::cart_size_t cpu_period(input logic pal);
		return pal ? `VP_CPU_DIV_PAL : `VP_CPU_DIV_NTSC;
	endfunction

	function automatic vp_glue_pkg::cart_size_t vdc_period(input logic pal);
		return pal ? `VP_VDC_DIV_PAL : `VP_VDC_DIV_NTSC;
	endfunction

	// Bank bits count only for large enough images, console bit 10 dropped
	function automatic vp_glue_pkg::rom_addr_t mapped_addr(input vp_glue_pkg::cart_size_t size,
		input vp_glue_pkg::cart_addr_t addr, input logic [1:0] bank);
		logic hi;
		logic mid;
		hi  = (size >= `VP_BANK1_SIZE) && bank[1];
		mid = (size >= `VP_BANK0_SIZE) && bank[0];
		return {hi, mid, addr[11], addr[9:0]};
	endfunction

	function automatic vp_glue_pkg::rgb18_t expected_rgb(input logic pal,
		input vp_glue_pkg::color_idx_t idx);
		vp_glue_pkg::rgb24_t e;
		vp_glue_pkg::byte_t  red;
		vp_glue_pkg::byte_t  green;
		vp_glue_pkg::byte_t  blue;
		e = pal ? vp_glue_pkg::palette_pal[idx] : vp_glue_pkg::palette_ntsc[idx];
		red   = e[23:16] >> 2;   // Six bits per channel
		green = e[15:8] >> 2;
		blue  = e[7:0] >> 2;
		return {red[5:0], green[5:0], blue[5:0]};
	endfunction

	////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////

	task automatic first_pulses(output vp_glue_pkg::cart_size_t cpu_n,
		output vp_glue_pkg::cart_size_t vdc_n);
		vp_glue_pkg::cart_size_t n;
		n = 0;
		cpu_n = 0;
		vdc_n = 0;
		while (cpu_n == 0 || vdc_n == 0) begin
			@(posedge clk_sys);
			n = n + 1;
			@(negedge clk_sys);
			if (cpu_en_o && cpu_n == 0)
				cpu_n = n;
			if (vdc_en_o && vdc_n == 0)
				vdc_n = n;
		end
	endtask

	task automatic measure_interval(input logic use_vdc, output vp_glue_pkg::cart_size_t n);
		n = 0;
		do @(negedge clk_sys); while (!(use_vdc ? vdc_en_o : cpu_en_o));
		do begin
			@(posedge clk_sys);
			n = n + 1;
			@(negedge clk_sys);
		end while (!(use_vdc ? vdc_en_o : cpu_en_o));
	endtask

	task automatic set_standard(input logic pal);
		vp_glue_pkg::cart_size_t cpu_n;
		vp_glue_pkg::cart_size_t vdc_n;
		if (pal_i !== pal) begin
			@(posedge clk_sys);
			pal_i <= pal;
			@(posedge clk_sys);   // Change registered here
			first_pulses(cpu_n, vdc_n);
			check_count("cpu_en_o after standard change", cpu_n, cpu_period(pal));
			check_count("vdc_en_o after standard change", vdc_n, vdc_period(pal));
		end
		measure_interval(1'b0, cpu_n);
		check_count("cpu_en_o interval", cpu_n, cpu_period(pal));
		measure_interval(1'b1, vdc_n);
		check_count("vdc_en_o interval", vdc_n, vdc_period(pal));
	endtask

	task automatic wb_access(input logic we, input vp_glue_pkg::rom_addr_t adr,
		input vp_glue_pkg::byte_t dat, output vp_glue_pkg::byte_t rdata);
		vp_glue_pkg::cart_size_t wait_n;
		wait_n = 0;
		@(posedge clk_sys);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i  <= we;
		wb_adr_i <= adr;
		wb_dat_i <= dat;
		@(negedge clk_sys);
		while (!wb_ack_o) begin
			@(posedge clk_sys);
			wait_n = wait_n + 1;
			@(negedge clk_sys);
		end
		check_count("wb_ack_o latency", wait_n, 16'd1);
		rdata = wb_dat_o;
		@(posedge clk_sys);
		wb_cyc_i <= 1'b0;   // Idle cycle before the next request
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
	endtask

	task automatic console_read(input vp_glue_pkg::cart_addr_t addr, input logic [1:0] bank,
		input logic psen_n, output vp_glue_pkg::byte_t data);
		@(posedge clk_sys);
		cart_addr_i <= addr;
		bank0_i     <= bank[0];
		bank1_i     <= bank[1];
		psen_n_i    <= psen_n;
		@(posedge clk_sys);
		@(negedge clk_sys);
		data = cart_data_o;
	endtask

	task automatic check_colour(input vp_glue_pkg::color_idx_t idx);
		@(posedge clk_sys);
		{r_i, g_i, b_i, luma_i} <= idx;
		do @(negedge clk_sys); while (!vdc_en_o);
		@(posedge clk_sys);   // Palette samples on this edge
		@(negedge clk_sys);
		check_rgb($sformatf("rgb_o for colour %h", idx), rgb_o, expected_rgb(pal_i, idx));
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		vp_glue_pkg::byte_t      got;
		vp_glue_pkg::cart_size_t cpu_n;
		vp_glue_pkg::cart_size_t vdc_n;
		logic [1:0]              bank;
		int                      i;
		int                      k;
		int                      a;
		reset = 1'b1;
		pal_i = 1'b0;
		load_active_i = 1'b0;
		{wb_cyc_i, wb_stb_i, wb_we_i} = 3'b000;
		wb_adr_i = '0;
		wb_dat_i = '0;
		cart_addr_i = '0;
		{bank0_i, bank1_i, psen_n_i} = 3'b001;
		{r_i, g_i, b_i, luma_i} = 4'h0;
		repeat (7) @(posedge clk_sys);
		@(negedge clk_sys);
		check_flag("cpu_en_o in reset", cpu_en_o, 1'b0);
		check_flag("vdc_en_o in reset", vdc_en_o, 1'b0);
		check_flag("wb_ack_o in reset", wb_ack_o, 1'b0);
		check_rgb("rgb_o in reset", rgb_o, '0);
		@(posedge clk_sys);
		reset <= 1'b0;
		first_pulses(cpu_n, vdc_n);
		check_count("first cpu_en_o after reset", cpu_n, cpu_period(1'b0));
		check_count("first vdc_en_o after reset", vdc_n, vdc_period(1'b0));

		for (i = 0; i < $size(CASES); i++) begin
			set_standard(CASES[i].pal);
			@(posedge clk_sys);
			load_active_i <= 1'b1;   // Clears the image size
			for (a = 0; a < CASES[i].size; a++) begin
				model[a] = vp_glue_pkg::byte_t'($random(seed));
				wb_access(1'b1, a, model[a], got);
			end
			@(posedge clk_sys);
			load_active_i <= 1'b0;
			for (a = 0; a < CASES[i].size; a++) begin
				wb_access(1'b0, a, 8'h00, got);
				check_byte($sformatf("wb_dat_o at %h", a), got, model[a]);
			end
			for (k = 0; k < 4; k++) begin
				bank = CASES[i].bank ^ k[1:0];
				console_read(CASES[i].probe_a, bank, 1'b0, got);
				check_byte("cart_data_o", got,
					model[mapped_addr(CASES[i].size, CASES[i].probe_a, bank)]);
				console_read(CASES[i].probe_b, bank, 1'b0, got);
				check_byte("cart_data_o", got,
					model[mapped_addr(CASES[i].size, CASES[i].probe_b, bank)]);
			end
			console_read(CASES[i].probe_a, CASES[i].bank, 1'b1, got);
			check_byte("cart_data_o with psen_n_i high", got, 8'hff);
			check_colour(CASES[i].color);
		end

		// Whole colour table in both standards
		for (k = 0; k < 2; k++) begin
			set_standard(k[0]);
			for (i = 0; i < 16; i++)
				check_colour(i[3:0]);
		end
		$display("All tests passed");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+source
source/vp_glue_pkg.sv
source/cart_mem_if.sv
source/vp_clock_enables.sv
source/vp_cart_loader.sv
source/vp_cart_rom.sv
source/vp_palette.sv
source/vp_glue_top.sv
dv/vp_glue_assertions.sv
dv/vp_glue_tb.sv

//--- Bender.yml
package:
  name: vp_glue

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/vp_glue_pkg.sv
      - source/cart_mem_if.sv
      - source/vp_clock_enables.sv
      - source/vp_cart_loader.sv
      - source/vp_cart_rom.sv
      - source/vp_palette.sv
      - source/vp_glue_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/vp_glue_assertions.sv
      - dv/vp_glue_tb.sv
